/* compile.f */
source/video_out_pkg.sv
source/obj_palette.sv
source/layer_mix.sv
source/color_out.sv
source/video_out_top.sv
sim/tb_video_out.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video output testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_video_out -f compile.f -o sim_video_out
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_video_out > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* sim/tb_video_out.sv */
`timescale 1ns/1ps
// Testbench for the video output pipeline
// Random pixel, palette and I/O traffic checked every cycle against a stage model
module tb_video_out;

    localparam int PAL_ADDR_W = 8;
    localparam int pal_depth  = 2 ** PAL_ADDR_W;

    logic                  CLK_32M = 1'b0;
    logic                  reset_n;
    logic                  pix_ce;
    logic [7:0]            obj_pix;
    logic [4:0]            char_r;
    logic [4:0]            char_g;
    logic [4:0]            char_b;
    logic                  char_pri;
    logic                  en_sprites;
    logic                  en_sprite_palette;
    logic                  pal_sel;
    logic                  mem_rd;
    logic                  mem_wr;
    logic [PAL_ADDR_W-1:0] cpu_addr;
    logic [1:0]            byte_sel;
    logic [15:0]           cpu_din;
    logic [15:0]           cpu_dout;
    logic                  cpu_dout_valid;
    logic [7:0]            io_addr;
    logic [7:0]            io_din;
    logic                  io_wr;
    logic [7:0]            r;
    logic [7:0]            g;
    logic [7:0]            b;
    logic                  rgb_valid;

    // ==================================================
    // Reference model state
    // ==================================================
    logic [15:0]           pal_model [pal_depth];
    logic [7:0]            flags_model  = 8'h00;
    logic                  m1_valid     = 1'b0;
    logic [7:0]            m1_idx;
    logic [15:0]           m1_word;
    logic [14:0]           m1_char;     // {b, g, r}
    logic                  m1_pri;
    logic                  m2_valid     = 1'b0;
    logic [14:0]           m2_rgb;
    logic                  m3_valid     = 1'b0;
    logic [23:0]           m3_rgb;      // {b, g, r} at output width
    logic                  m_dout_valid = 1'b0;
    logic [15:0]           m_dout;
    logic [PAL_ADDR_W-1:0] addr_q [$];

    video_out_top #(.PAL_ADDR_W(PAL_ADDR_W)) DUT (.*);

    always #20 CLK_32M = ~CLK_32M;

    function automatic logic [7:0] widen(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // Stage 2 result as {b, g, r}
    function automatic logic [14:0] mix_pixel(input logic [7:0] idx, input logic [15:0] word,
                                              input logic [14:0] chr, input logic pri,
                                              input logic spr_on, input logic pal_on);
        logic opaque;
        opaque = (idx[3:0] != 4'h0) && spr_on;
        if (!(opaque && pri)) return chr;
        if (pal_on) return word[14:0];
        return {3{idx[3:0], 1'b0}};
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Model state after the coming clock edge from the inputs driven now
    task automatic model_step();
        if (!reset_n) begin
            {m1_valid, m2_valid, m3_valid, m_dout_valid} = 4'b0000;
            flags_model = 8'h00;
            return;
        end
        m3_valid = m2_valid;
        m3_rgb   = flags_model[3] ? 24'h0 :
                   {widen(m2_rgb[14:10]), widen(m2_rgb[9:5]), widen(m2_rgb[4:0])};
        m2_valid = m1_valid;
        m2_rgb   = mix_pixel(m1_idx, m1_word, m1_char, m1_pri, en_sprites, en_sprite_palette);
        m1_valid = pix_ce;
        m1_idx   = obj_pix;
        m1_word  = pal_model[PAL_ADDR_W'(obj_pix)];   // Old word on a same-address write
        m1_char  = {char_b, char_g, char_r};
        m1_pri   = char_pri;
        m_dout_valid = pal_sel && mem_rd;
        if (m_dout_valid) m_dout = pal_model[cpu_addr];
        if (io_wr && io_addr == 8'h02) flags_model = io_din;
        if (pal_sel && mem_wr) begin
            if (byte_sel[0]) pal_model[cpu_addr][7:0]  = cpu_din[7:0];
            if (byte_sel[1]) pal_model[cpu_addr][15:8] = cpu_din[15:8];
        end
    endtask

    // One clock and a compare of every output with the model
    task automatic clock_cycle();
        model_step();
        @(posedge CLK_32M);
        #1;
        check("rgb_valid", 16'(rgb_valid), 16'(m3_valid));
        check("cpu_dout_valid", 16'(cpu_dout_valid), 16'(m_dout_valid));
        if (m3_valid) begin
            check("r", 16'(r), 16'(m3_rgb[7:0]));
            check("g", 16'(g), 16'(m3_rgb[15:8]));
            check("b", 16'(b), 16'(m3_rgb[23:16]));
        end
        if (m_dout_valid) check("cpu_dout", cpu_dout, m_dout);
    endtask

    task automatic clear_strobes();
        {pix_ce, pal_sel, mem_rd, mem_wr, io_wr} = 5'b00000;
    endtask

    task automatic pal_write(input logic [PAL_ADDR_W-1:0] addr, input logic [15:0] data,
                             input logic [1:0] bsel);
        {pal_sel, mem_wr, mem_rd} = 3'b110;
        cpu_addr = addr;
        cpu_din  = data;
        byte_sel = bsel;
        clock_cycle();
        {pal_sel, mem_wr} = 2'b00;
    endtask

    task automatic pal_read(input logic [PAL_ADDR_W-1:0] addr);
        {pal_sel, mem_rd, mem_wr} = 3'b110;
        cpu_addr = addr;
        clock_cycle();
        {pal_sel, mem_rd} = 2'b00;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        io_wr   = 1'b1;
        io_addr = port;
        io_din  = data;
        clock_cycle();
        io_wr   = 1'b0;
    endtask

    task automatic send_pixel(input logic [7:0] idx, input logic [14:0] chr, input logic pri);
        pix_ce   = 1'b1;
        obj_pix  = idx;
        {char_b, char_g, char_r} = chr;
        char_pri = pri;
        clock_cycle();
        pix_ce   = 1'b0;
    endtask

    // Random opaque index with a nonzero low nibble
    function automatic logic [7:0] opaque_idx();
        return {4'($urandom), 4'($urandom % 15 + 1)};
    endfunction

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        clear_strobes();
        while (m1_valid || m2_valid || m3_valid || rgb_valid) begin
            if (waited == 10) begin
                $display("Pixel pipeline did not drain within 10 cycles");
                $display("Test failures found");
                $fatal(1, "drain timeout");
            end
            clock_cycle();
            waited++;
        end
    endtask

    task automatic random_traffic(input int cycles);
        int op;
        repeat (cycles) begin
            pix_ce   = 1'($urandom);
            obj_pix  = 8'($urandom);
            {char_b, char_g, char_r} = 15'($urandom);
            char_pri = 1'($urandom);
            if ($urandom % 16 == 0) en_sprites = ~en_sprites;
            if ($urandom % 16 == 0) en_sprite_palette = ~en_sprite_palette;
            op = int'($urandom % 8);
            {pal_sel, mem_wr, mem_rd} = {op < 2, op == 0, op == 1};
            cpu_addr = PAL_ADDR_W'($urandom);
            byte_sel = 2'($urandom);
            cpu_din  = 16'($urandom);
            io_wr    = ($urandom % 12 == 0);
            io_addr  = ($urandom % 2 == 0) ? 8'h02 : 8'($urandom);
            io_din   = 8'($urandom);
            clock_cycle();
        end
        clear_strobes();
    endtask

    initial begin
        void'($urandom(32'haaa71ffc));
        reset_n = 1'b0;
        clear_strobes();
        {en_sprites, en_sprite_palette, char_pri} = 3'b000;
        {obj_pix, char_r, char_g, char_b} = 23'h0;
        {cpu_addr, byte_sel, cpu_din, io_addr, io_din} = '0;

        // Reset held with strobes active so nothing may come out
        repeat (8) begin
            {pix_ce, pal_sel, mem_rd} = 3'b111;
            obj_pix = 8'($urandom);
            clock_cycle();
        end
        reset_n = 1'b1;
        clear_strobes();
        send_pixel(8'h11, 15'h7fff, 1'b1);      // Must not be blanked
        drain_pipeline();

        for (int a = 0; a < pal_depth; a++) begin
            pal_write(PAL_ADDR_W'(a), (16'(a) * 16'h0101) ^ 16'h6c93, 2'b11);
        end

        // Byte-selective writes and readback
        repeat (32) begin
            addr_q.push_back(PAL_ADDR_W'($urandom));
            pal_write(addr_q[$], 16'($urandom), 2'($urandom));
        end
        while (addr_q.size() > 0) begin
            pal_read(addr_q.pop_front());
            if ($urandom % 4 == 0) clock_cycle();
        end
        clock_cycle();

        {en_sprites, en_sprite_palette} = 2'b11;
        repeat (24) send_pixel(opaque_idx(), 15'($urandom), 1'b1);

        // Lookup and CPU write on the same address in one cycle
        pix_ce   = 1'b1;
        obj_pix  = 8'h35;
        {char_b, char_g, char_r} = 15'($urandom);
        char_pri = 1'b1;
        pal_write(PAL_ADDR_W'(8'h35), ~pal_model[8'h35], 2'b11);
        pix_ce   = 1'b0;
        send_pixel(8'h35, 15'($urandom), 1'b1);   // New word from here on

        en_sprite_palette = 1'b0;
        repeat (24) send_pixel(opaque_idx(), 15'($urandom), 1'b1);
        drain_pipeline();

        // Character colour wins
        en_sprite_palette = 1'b1;
        repeat (8) send_pixel({4'($urandom), 4'h0}, 15'($urandom), 1'b1);
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'b0);
        en_sprites = 1'b0;
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'b1);
        drain_pipeline();
        random_traffic(400);
        drain_pipeline();

        // Colour blank set and cleared with writes to other ports in between
        {en_sprites, en_sprite_palette} = 2'b11;
        io_write(8'h02, 8'h08);
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'($urandom));
        io_write(8'h03, 8'h00);
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'($urandom));
        io_write(8'h02, 8'hf7);
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'($urandom));
        io_write(8'h12, 8'h08);
        repeat (8) send_pixel(opaque_idx(), 15'($urandom), 1'($urandom));
        drain_pipeline();

        $display("All tests passed!");
        $finish;
    end

endmodule

/* source/color_out.sv */
`timescale 1ns/1ps
// Colour output, pixel pipeline stage 3
// Holds the system flags written over CPU I/O, blanks the picture on
// colour blank and widens each channel to the output width
module color_out (
    input  logic                                CLK_32M,
    input  logic                                reset_n,

    // CPU I/O port
    input  logic                                io_wr,
    input  logic [7:0]                          io_addr,
    input  logic [7:0]                          io_din,

    // From stage 2
    input  logic                                s2_valid,
    input  video_out_pkg::color5_t              s2_r,
    input  video_out_pkg::color5_t              s2_g,
    input  video_out_pkg::color5_t              s2_b,

    // Video out
    output logic [video_out_pkg::out_w-1:0]     r,
    output logic [video_out_pkg::out_w-1:0]     g,
    output logic [video_out_pkg::out_w-1:0]     b,
    output logic                                rgb_valid
);
    import video_out_pkg::*;

    logic [7:0] sys_flags;
    logic       cblk;

    // Top bits repeat below so full scale maps to full scale
    function automatic logic [out_w-1:0] expand(input color5_t c);
        return {c, c[color_w-1 -: out_w-color_w]};
    endfunction

    assign cblk = sys_flags[cblk_bit];

    // ==================================================
    // System flags
    // ==================================================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags <= sys_flags_rst;
        end else if (io_wr && io_addr == sys_flags_port) begin
            sys_flags <= io_din;
        end
    end

    // ==================================================
    // Stage 3 pipeline register
    // ==================================================
    always_ff @(posedge CLK_32M) begin
        r <= cblk ? '0 : expand(s2_r);
        g <= cblk ? '0 : expand(s2_g);
        b <= cblk ? '0 : expand(s2_b);
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= s2_valid;
        end
    end

    // Valid chain is clean all the way from the pixel input
    assert property (@(posedge CLK_32M) disable iff (!reset_n) !$isunknown(rgb_valid))
        else $error("color_out: rgb_valid unknown after reset");

endmodule

/* source/layer_mix.sv */
`timescale 1ns/1ps
// Layer mixer, pixel pipeline stage 2
// Picks sprite or character colour from sprite opacity and character
// priority, with an optional grey bypass of the object palette
module layer_mix (
    input  logic                    CLK_32M,
    input  logic                    reset_n,

    // Layer controls
    input  logic                    en_sprites,
    input  logic                    en_sprite_palette,

    // From stage 1
    input  logic                    s1_valid,
    input  logic [7:0]              s1_obj_pix,
    input  video_out_pkg::color5_t  s1_pal_r,
    input  video_out_pkg::color5_t  s1_pal_g,
    input  video_out_pkg::color5_t  s1_pal_b,
    input  video_out_pkg::color5_t  s1_char_r,
    input  video_out_pkg::color5_t  s1_char_g,
    input  video_out_pkg::color5_t  s1_char_b,
    input  logic                    s1_char_pri,

    // To stage 3
    output logic                    s2_valid,
    output video_out_pkg::color5_t  s2_r,
    output video_out_pkg::color5_t  s2_g,
    output video_out_pkg::color5_t  s2_b
);
    import video_out_pkg::*;

    logic    obj_opaque;
    logic    obj_wins;
    color5_t obj_grey;
    color5_t obj_r;
    color5_t obj_g;
    color5_t obj_b;

    // Index 0 of each 16-colour group is transparent
    assign obj_opaque = (|s1_obj_pix[3:0]) & en_sprites;
    assign obj_wins   = obj_opaque & s1_char_pri;
    assign obj_grey   = {s1_obj_pix[3:0], 1'b0};    // Palette bypass

    always_comb begin
        if (en_sprite_palette) begin
            obj_r = s1_pal_r;
            obj_g = s1_pal_g;
            obj_b = s1_pal_b;
        end else begin
            obj_r = obj_grey;
            obj_g = obj_grey;
            obj_b = obj_grey;
        end
    end

    // ==================================================
    // Stage 2 pipeline register
    // ==================================================
    always_ff @(posedge CLK_32M) begin
        s2_r <= obj_wins ? obj_r : s1_char_r;
        s2_g <= obj_wins ? obj_g : s1_char_g;
        s2_b <= obj_wins ? obj_b : s1_char_b;
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

endmodule

/* source/obj_palette.sv */
`timescale 1ns/1ps
// Object palette, pixel pipeline stage 1
// Palette RAM with a byte-writable CPU port and a registered lookup
// for sprite pixel indices. Character colours ride alongside.
module obj_palette #(
    parameter int PAL_ADDR_W = video_out_pkg::default_pal_addr_w
) (
    input  logic                      CLK_32M,
    input  logic                      reset_n,

    // Pixel input
    input  logic                      pix_ce,
    input  logic [7:0]                obj_pix,
    input  video_out_pkg::color5_t    char_r,
    input  video_out_pkg::color5_t    char_g,
    input  video_out_pkg::color5_t    char_b,
    input  logic                      char_pri,

    // CPU palette port
    input  logic                      pal_sel,
    input  logic                      mem_rd,
    input  logic                      mem_wr,
    input  logic [PAL_ADDR_W-1:0]     cpu_addr,
    input  logic [1:0]                byte_sel,
    input  video_out_pkg::pal_word_t  cpu_din,
    output video_out_pkg::pal_word_t  cpu_dout,
    output logic                      cpu_dout_valid,

    // To stage 2
    output logic                      s1_valid,
    output logic [7:0]                s1_obj_pix,
    output video_out_pkg::color5_t    s1_pal_r,
    output video_out_pkg::color5_t    s1_pal_g,
    output video_out_pkg::color5_t    s1_pal_b,
    output video_out_pkg::color5_t    s1_char_r,
    output video_out_pkg::color5_t    s1_char_g,
    output video_out_pkg::color5_t    s1_char_b,
    output logic                      s1_char_pri
);
    import video_out_pkg::*;

    localparam int pal_depth = 2 ** PAL_ADDR_W;

    pal_word_t             pal_ram [pal_depth];
    pal_word_t             pix_word;        // Looked-up word for the pixel in stage 1
    logic                  cpu_wr;
    logic                  cpu_rd;
    logic [PAL_ADDR_W-1:0] pix_addr;

    assign cpu_wr   = pal_sel & mem_wr;
    assign cpu_rd   = pal_sel & mem_rd;
    assign pix_addr = PAL_ADDR_W'(obj_pix);

    // ==================================================
    // Palette RAM
    // ==================================================
    always_ff @(posedge CLK_32M) begin
        if (cpu_wr) begin
            if (byte_sel[0]) pal_ram[cpu_addr][7:0]  <= cpu_din[7:0];
            if (byte_sel[1]) pal_ram[cpu_addr][15:8] <= cpu_din[15:8];
        end
        if (cpu_rd) cpu_dout <= pal_ram[cpu_addr];

        pix_word <= pal_ram[pix_addr];   // Sees the old word on a same-address write
    end

    // ==================================================
    // Stage 1 pipeline register
    // ==================================================
    always_ff @(posedge CLK_32M) begin
        s1_obj_pix  <= obj_pix;
        s1_char_r   <= char_r;
        s1_char_g   <= char_g;
        s1_char_b   <= char_b;
        s1_char_pri <= char_pri;
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid       <= 1'b0;
            cpu_dout_valid <= 1'b0;
        end else begin
            s1_valid       <= pix_ce;
            cpu_dout_valid <= cpu_rd;   // One cycle read latency
        end
    end

    assign s1_pal_r = pix_word.red;
    assign s1_pal_g = pix_word.green;
    assign s1_pal_b = pix_word.blue;

    // CPU never reads and writes the palette in the same cycle
    assert property (@(posedge CLK_32M) disable iff (!reset_n) !(cpu_rd && cpu_wr))
        else $error("obj_palette: palette read and write in the same cycle");

endmodule

/* source/video_out_pkg.sv */
// Video output package
// Colour widths, palette word layout, CPU I/O port codes and reset values
// shared by the three pixel pipeline stages
package video_out_pkg;

    // ==================================================
    // Colour widths
    // ==================================================
    parameter int color_w = 5;  // Channel width as stored in palette and tiles
    parameter int out_w   = 8;  // Channel width at the video output

    // One stored colour channel
    typedef logic [color_w-1:0] color5_t;

    // ==================================================
    // Palette word
    // ==================================================
    // Red in the low bits, blue just under the spare bit
    typedef struct packed {
        logic    spare;         // Kept for CPU readback, no colour effect
        color5_t blue;
        color5_t green;
        color5_t red;
    } pal_word_t;

    parameter int default_pal_addr_w = 8;   // 256 palette entries

    // ==================================================
    // CPU I/O ports
    // ==================================================
    // Only the system flags port is decoded here
    typedef enum logic [7:0] {
        sys_flags_port = 8'h02
    } io_port_e;

    parameter int cblk_bit = 3;             // Colour blank flag in system flags

    // Reset values
    parameter logic [7:0] sys_flags_rst = 8'h00;   // Blanking off after reset

endpackage

/* source/video_out_top.sv */
`timescale 1ns/1ps
// Video output top level
// Three-stage colour path: object palette, layer mix, colour output
module video_out_top #(
    parameter int PAL_ADDR_W = video_out_pkg::default_pal_addr_w
) (
    input  logic                                CLK_32M,
    input  logic                                reset_n,

    // Pixel input
    input  logic                                pix_ce,
    input  logic [7:0]                          obj_pix,
    input  video_out_pkg::color5_t              char_r,
    input  video_out_pkg::color5_t              char_g,
    input  video_out_pkg::color5_t              char_b,
    input  logic                                char_pri,
    input  logic                                en_sprites,
    input  logic                                en_sprite_palette,

    // CPU palette port
    input  logic                                pal_sel,
    input  logic                                mem_rd,
    input  logic                                mem_wr,
    input  logic [PAL_ADDR_W-1:0]               cpu_addr,
    input  logic [1:0]                          byte_sel,
    input  video_out_pkg::pal_word_t            cpu_din,
    output video_out_pkg::pal_word_t            cpu_dout,
    output logic                                cpu_dout_valid,

    // CPU I/O port
    input  logic                                io_wr,
    input  logic [7:0]                          io_addr,
    input  logic [7:0]                          io_din,

    // Video out
    output logic [video_out_pkg::out_w-1:0]     r,
    output logic [video_out_pkg::out_w-1:0]     g,
    output logic [video_out_pkg::out_w-1:0]     b,
    output logic                                rgb_valid
);
    import video_out_pkg::*;

    // Stage 1 to stage 2
    logic       s1_valid;
    logic [7:0] s1_obj_pix;
    color5_t    s1_pal_r;
    color5_t    s1_pal_g;
    color5_t    s1_pal_b;
    color5_t    s1_char_r;
    color5_t    s1_char_g;
    color5_t    s1_char_b;
    logic       s1_char_pri;

    // Stage 2 to stage 3
    logic       s2_valid;
    color5_t    s2_r;
    color5_t    s2_g;
    color5_t    s2_b;

    obj_palette #(
        .PAL_ADDR_W(PAL_ADDR_W)
    ) u_obj_palette (
        .CLK_32M(CLK_32M),              .reset_n(reset_n),
        .pix_ce(pix_ce),                .obj_pix(obj_pix),
        .char_r(char_r),                .char_g(char_g),
        .char_b(char_b),                .char_pri(char_pri),
        .pal_sel(pal_sel),              .mem_rd(mem_rd),
        .mem_wr(mem_wr),                .cpu_addr(cpu_addr),
        .byte_sel(byte_sel),            .cpu_din(cpu_din),
        .cpu_dout(cpu_dout),            .cpu_dout_valid(cpu_dout_valid),
        .s1_valid(s1_valid),            .s1_obj_pix(s1_obj_pix),
        .s1_pal_r(s1_pal_r),            .s1_pal_g(s1_pal_g),
        .s1_pal_b(s1_pal_b),            .s1_char_r(s1_char_r),
        .s1_char_g(s1_char_g),          .s1_char_b(s1_char_b),
        .s1_char_pri(s1_char_pri)
    );

    layer_mix u_layer_mix (
        .CLK_32M(CLK_32M),              .reset_n(reset_n),
        .en_sprites(en_sprites),        .en_sprite_palette(en_sprite_palette),
        .s1_valid(s1_valid),            .s1_obj_pix(s1_obj_pix),
        .s1_pal_r(s1_pal_r),            .s1_pal_g(s1_pal_g),
        .s1_pal_b(s1_pal_b),            .s1_char_r(s1_char_r),
        .s1_char_g(s1_char_g),          .s1_char_b(s1_char_b),
        .s1_char_pri(s1_char_pri),
        .s2_valid(s2_valid),            .s2_r(s2_r),
        .s2_g(s2_g),                    .s2_b(s2_b)
    );

    color_out u_color_out (
        .CLK_32M(CLK_32M),              .reset_n(reset_n),
        .io_wr(io_wr),                  .io_addr(io_addr),
        .io_din(io_din),
        .s2_valid(s2_valid),            .s2_r(s2_r),
        .s2_g(s2_g),                    .s2_b(s2_b),
        .r(r),                          .g(g),
        .b(b),                          .rgb_valid(rgb_valid)
    );

endmodule
